//--- filelist.f
+incdir+rtl
rtl/cart_pkg.sv
rtl/cart_header_capture.sv
rtl/mbc_bank_regs.sv
rtl/mbc_addr_map.sv
rtl/cart_ram.sv
rtl/cart_mapper_top.sv
tests/tb_cart_mapper.sv

//--- Bender.yml
package:
  name: cart_mapper

export_include_dirs:
  - rtl

sources:
  - rtl/cart_pkg.sv
  - rtl/cart_header_capture.sv
  - rtl/mbc_bank_regs.sv
  - rtl/mbc_addr_map.sv
  - rtl/cart_ram.sv
  - rtl/cart_mapper_top.sv
  - target: simulation
    files:
      - tests/tb_cart_mapper.sv

//--- tests/tb_cart_mapper.sv
// self-checking testbench that runs the cartridge mapper top level as the simulation top
`timescale 1ns/100ps
`include "cart_defs.svh"

module tb_cart_mapper;

	localparam int          PERIOD   = 40;
	localparam int          N_ACCESS = 150;       // rough count of bus accesses in all tests
	localparam logic [15:0] SEED     = 16'd50287;

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    dl_active, dl_wr, cart_rd, cart_wr;
	logic [`DL_ADDR_W-1:0]   dl_addr;
	logic [`DL_DATA_W-1:0]   dl_data;
	logic [`CART_ADDR_W-1:0] cart_addr;
	logic [`CART_DATA_W-1:0] cart_di;
	logic                    rom_rd, rom_wr, cram_rd_valid;
	logic [`ROM_WADDR_W-1:0] rom_addr;
	logic [`DL_DATA_W-1:0]   rom_wdata;
	logic [`CART_DATA_W-1:0] cram_rdata;
	int                      errors = 0;
	logic [15:0]             lfsr = SEED;

	// reference model of the cart
	cart_pkg::mbc_kind_t m_kind;
	logic [8:0]          m_rom_mask, m_rom_bank;
	logic [3:0]          m_ram_mask, m_ram_bank;
	logic                m_mode, m_rtc, m_en;
	logic [7:0]          m_mem [int]; // cram address -> byte

	// expected values delayed to line up with the dut outputs
	logic [21:0] exp_addr, exp_addr_d1, exp_addr_d2;
	logic [15:0] exp_wdata, exp_wdata_d1, exp_wdata_d2;
	logic [7:0]  exp_rdata, exp_rdata_d1, exp_rdata_d2, exp_rdata_d3;

	cart_mapper_top u_dut (.*);

	always #(PERIOD/2) clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		exp_addr_d1  <= exp_addr;
		exp_addr_d2  <= exp_addr_d1;
		exp_wdata_d1 <= exp_wdata;
		exp_wdata_d2 <= exp_wdata_d1;
		exp_rdata_d1 <= exp_rdata;
		exp_rdata_d2 <= exp_rdata_d1;
		exp_rdata_d3 <= exp_rdata_d2;
	end

	// ------------------------------
	// checks
	a_dl_fwd: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> ##2 (rom_wr && rom_addr == exp_addr_d2 && rom_wdata == exp_wdata_d2))
		else begin
			errors++;
			$display("Error: rom_wr %h rom_addr %h rom_wdata %h, expected 1 %h %h",
				rom_wr, rom_addr, rom_wdata, exp_addr_d2, exp_wdata_d2);
		end

	a_rom_rd: assert property (@(posedge clk_sys) disable iff (reset)
		(cart_rd && !cart_addr[15]) |-> ##2 (rom_rd && rom_addr == exp_addr_d2))
		else begin
			errors++;
			$display("Error: rom_addr %h rom_rd %h, expected %h", rom_addr, rom_rd, exp_addr_d2);
		end

	a_cram_rd: assert property (@(posedge clk_sys) disable iff (reset)
		(cart_rd && cart_addr[15:13] == `WIN_CRAM)
		|-> ##3 (cram_rd_valid && cram_rdata == exp_rdata_d3))
		else begin
			errors++;
			$display("Error: cram_rd_valid %h cram_rdata %h, expected 1 %h",
				cram_rd_valid, cram_rdata, exp_rdata_d3);
		end

	// ------------------------------
	// reference functions
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // galois step
		end
		return r;
	endfunction

	function automatic cart_pkg::mbc_kind_t kind_of(input logic [7:0] t);
		if (t >= 1 && t <= 3)   return cart_pkg::MBC_1;
		if (t >= 5 && t <= 6)   return cart_pkg::MBC_2;
		if (t >= 15 && t <= 19) return cart_pkg::MBC_3;
		if (t >= 25 && t <= 30) return cart_pkg::MBC_5;
		return cart_pkg::MBC_NONE;
	endfunction

	function automatic logic [21:0] exp_rom(input logic [15:0] a);
		logic [8:0] b;
		case (m_kind)
			cart_pkg::MBC_1: b = {2'b00, m_mode ? 2'b00 : m_ram_bank[1:0], m_rom_bank[4:0]};
			cart_pkg::MBC_2, cart_pkg::MBC_3: b = {2'b00, m_rom_bank[6:0]};
			cart_pkg::MBC_5: b = m_rom_bank;
			default: b = 9'h1FF; // bank follows address bit 14 only
		endcase
		b = a[14] ? (b & ((m_kind == cart_pkg::MBC_NONE) ? 9'd1 : m_rom_mask)) : 9'd0;
		return {b, a[13:1]};
	endfunction

	function automatic int cram_index(input logic [15:0] a);
		logic [3:0] b;
		case (m_kind)
			cart_pkg::MBC_1: b = (m_mode ? m_ram_bank : 4'h0) & m_ram_mask;
			cart_pkg::MBC_3, cart_pkg::MBC_5: b = m_ram_bank & m_ram_mask;
			default: b = 4'h0;
		endcase
		return {b, a[12:0]};
	endfunction

	function automatic logic [7:0] exp_read(input logic [15:0] a);
		logic [7:0] s;
		s = m_mem.exists(cram_index(a)) ? m_mem[cram_index(a)] : 8'h00;
		if (!m_en) return 8'hFF;
		if (m_kind == cart_pkg::MBC_2 && a < 16'hA200) return {4'hF, s[3:0]};
		if (m_kind == cart_pkg::MBC_3 && m_rtc) return 8'h00;
		return s;
	endfunction

	// ------------------------------
	// stimulus
	task automatic model_write(input logic [15:0] a, input logic [7:0] d);
		case (a[15:13])
			3'd0: m_en = (d[3:0] == 4'hA);
			3'd1: if (m_kind == cart_pkg::MBC_5) begin
				if (a[12]) m_rom_bank[8] = d[0];
				else       m_rom_bank[7:0] = d;
			end else begin
				m_rom_bank = (d[6:0] == 7'd0) ? 9'd1 : {2'b00, d[6:0]};
			end
			3'd2: if (m_kind == cart_pkg::MBC_3) begin
				m_rtc = d[3];
				if (!d[3]) m_ram_bank = {2'b00, d[1:0]};
			end else begin
				m_ram_bank = (m_kind == cart_pkg::MBC_5) ? d[3:0] : {2'b00, d[1:0]};
			end
			3'd3: if (m_kind == cart_pkg::MBC_1) m_mode = d[0];
			3'd5: m_mem[cram_index(a)] = d; // stored even while disabled
			default: ;
		endcase
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk_sys);
		cart_wr   <= 1'b1;
		cart_addr <= a;
		cart_di   <= d;
		@(posedge clk_sys);
		cart_wr <= 1'b0;
		model_write(a, d);
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic cpu_read(input logic [15:0] a);
		@(posedge clk_sys);
		cart_rd   <= 1'b1;
		cart_addr <= a;
		exp_addr  <= exp_rom(a);
		exp_rdata <= exp_read(a);
		@(posedge clk_sys);
		cart_rd <= 1'b0;
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic dl_word(input logic [24:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		dl_wr     <= 1'b1;
		dl_addr   <= a;
		dl_data   <= d;
		exp_addr  <= a[22:1]; // byte to word address
		exp_wdata <= d;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic load_header(input logic [7:0] t, input logic [7:0] rs, input logic [7:0] ms);
		logic [24:0] ra;
		@(posedge clk_sys);
		dl_active <= 1'b1;
		dl_word(`HDR_TYPE_OFS, {t, 8'h00});
		dl_word(`HDR_SIZE_OFS, {ms, rs});
		repeat (2) begin
			ra       = '0;
			ra[24:9] = rand_bits(16);
			ra[8:1]  = 8'(rand_bits(8));
			ra[9]    = 1'b1; // stays clear of the header words
			dl_word(ra, rand_bits(16));
		end
		@(posedge clk_sys);
		dl_active <= 1'b0;
		m_kind     = kind_of(t);
		m_rom_mask = (rs <= 8) ? (9'd1 << (rs + 1)) - 9'd1 : 9'h07F;
		m_ram_mask = (ms >= 4) ? 4'hF : ((ms == 3) ? 4'h3 : 4'h0);
		m_rom_bank = 9'd1;
		m_ram_bank = 4'd0;
		{m_mode, m_rtc, m_en} = 3'b000;
		repeat (2) @(posedge clk_sys);
	endtask

	// ------------------------------
	initial begin
		logic [7:0]  types [5];
		logic [15:0] a;
		logic [15:0] addrs [$];
		types = '{8'h00, 8'h01, 8'h05, 8'h11, 8'h19};
		{dl_active, dl_wr, cart_rd, cart_wr} = 4'b0000;
		{dl_addr, dl_data, cart_addr, cart_di} = '0;
		{exp_addr, exp_wdata, exp_rdata} = '0;
		reset = 1'b1;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		assert (!rom_rd && !rom_wr && !cram_rd_valid) else begin
			errors++;
			$display("a strobe output is active right after reset");
		end

		// download and header capture for each kind
		foreach (types[i]) begin
			load_header(types[i], 8'd3, 8'd3);
			cpu_write(16'h2000, 8'h05);
			cpu_read(16'h4000 | rand_bits(14));
		end

		// mbc1 banks, mode and bank 0 remap
		load_header(8'h01, 8'd5, 8'd3);
		for (int i = 0; i < 6; i++) begin
			cpu_write(16'h2000, (i == 0) ? 8'h00 : 8'(rand_bits(8)));
			cpu_write(16'h4000, 8'(rand_bits(8)));
			cpu_write(16'h6000, 8'(rand_bits(1)));
			cpu_read(16'h4000 | rand_bits(14));
			cpu_read(rand_bits(14));
		end

		// mbc5 nine bit bank
		load_header(8'h19, 8'd8, 8'd4);
		for (int i = 0; i < 6; i++) begin
			a = (i == 0) ? 16'h0000 : ((i == 1) ? 16'h0100 : rand_bits(9));
			cpu_write(16'h2000, a[7:0]);
			cpu_write(16'h3000, a[15:8]);
			cpu_read(16'h4000 | rand_bits(14));
		end

		// ram enable, write and read back across banks, then disable
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 8; i++) begin
			cpu_write(16'h4000, 8'(rand_bits(4)));
			a = 16'hA000 | rand_bits(13);
			addrs.push_back(a);
			cpu_write(a, 8'(rand_bits(8)));
			cpu_read(a);
		end
		cpu_write(16'h0000, 8'h00);
		cpu_read(addrs[0]);
		cpu_read(addrs[7]);

		// mbc2 nibble ram, mbc3 rtc mode
		load_header(8'h05, 8'd2, 8'd0);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA010, 8'(rand_bits(8)));
		cpu_read(16'hA010);
		load_header(8'h11, 8'd4, 8'd3);
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h02);
		cpu_write(16'hA123, 8'(rand_bits(8)));
		cpu_write(16'h4000, 8'h08);
		cpu_read(16'hA123);
		cpu_write(16'h4000, 8'h02);
		cpu_read(16'hA123);

		// no mbc cart ignores the bank writes
		load_header(8'h00, 8'd0, 8'd0);
		cpu_write(16'h2000, 8'h06); // even bank, so a masked register would read as bank 0
		cpu_read(16'h4000 | rand_bits(14));
		cpu_read(rand_bits(14));

		repeat (4) @(posedge clk_sys);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(PERIOD * (N_ACCESS * 40 + 1000));
		$display("timeout, the tests did not finish in time");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- rtl/cart_mapper_top.sv
// cartridge side of the console core: header capture feeding bank regs, address map and cart ram
`timescale 1ns/100ps
`include "cart_defs.svh"

module cart_mapper_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	// image download
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [`DL_DATA_W-1:0]   dl_data,
	// cpu cartridge bus
	input  logic                    cart_rd,
	input  logic                    cart_wr,
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic [`CART_DATA_W-1:0] cart_di,
	// rom store
	output logic                    rom_rd,
	output logic                    rom_wr,
	output logic [`ROM_WADDR_W-1:0] rom_addr,
	output logic [`DL_DATA_W-1:0]   rom_wdata,
	// cartridge ram read back
	output logic                    cram_rd_valid,
	output logic [`CART_DATA_W-1:0] cram_rdata
);

	// ------------------------------
	// header config
	cart_pkg::mbc_kind_t     mbc_kind;
	cart_pkg::rom_bank_t     rom_mask;
	cart_pkg::ram_bank_t     ram_mask;
	// bank registers
	cart_pkg::rom_bank_t     rom_bank_reg;
	cart_pkg::ram_bank_t     ram_bank_reg;
	logic                    mbc1_mode;
	logic                    rtc_mode;
	logic                    ram_enable;
	// stage 1 -> 2
	logic                    s1_rd;
	logic                    s1_wr;
	logic [`CART_ADDR_W-1:0] s1_addr;
	logic [`CART_DATA_W-1:0] s1_data;
	// stage 2 -> 3
	logic                    s2_cram_rd;
	logic                    s2_cram_wr;
	logic [`CRAM_ADDR_W-1:0] s2_cram_addr;
	logic [`CART_DATA_W-1:0] s2_cram_data;
	logic                    s2_mbc2_nibble;

	cart_header_capture u_hdr (
		.clk_sys, .reset, .dl_active, .dl_wr, .dl_addr, .dl_data,
		.mbc_kind, .rom_mask, .ram_mask
	);

	mbc_bank_regs u_regs (
		.clk_sys, .reset, .dl_active, .mbc_kind,
		.cart_rd, .cart_wr, .cart_addr, .cart_di,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode, .rtc_mode, .ram_enable,
		.s1_rd, .s1_wr, .s1_addr, .s1_data
	);

	mbc_addr_map u_map (
		.clk_sys, .reset, .mbc_kind, .rom_mask, .ram_mask,
		.rom_bank_reg, .ram_bank_reg, .mbc1_mode,
		.dl_wr, .dl_addr, .dl_data,
		.s1_rd, .s1_wr, .s1_addr, .s1_data,
		.rom_rd, .rom_wr, .rom_addr, .rom_wdata,
		.s2_cram_rd, .s2_cram_wr, .s2_cram_addr, .s2_cram_data, .s2_mbc2_nibble
	);

	cart_ram u_cram (
		.clk_sys, .reset, .ram_enable, .rtc_mode, .mbc_kind,
		.s2_cram_rd, .s2_cram_wr, .s2_cram_addr, .s2_cram_data, .s2_mbc2_nibble,
		.cram_rd_valid, .cram_rdata
	);

endmodule

//--- rtl/cart_ram.sv
// pipeline stage 3: battery cartridge ram, up to 128 KB, with the per-mapper read data rules
`timescale 1ns/100ps
`include "cart_defs.svh"

module cart_ram (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ram_enable,
	input  logic                    rtc_mode,
	input  cart_pkg::mbc_kind_t     mbc_kind,
	input  logic                    s2_cram_rd,
	input  logic                    s2_cram_wr,
	input  logic [`CRAM_ADDR_W-1:0] s2_cram_addr,
	input  logic [`CART_DATA_W-1:0] s2_cram_data,
	input  logic                    s2_mbc2_nibble,
	output logic                    cram_rd_valid,
	output logic [`CART_DATA_W-1:0] cram_rdata
);

	localparam int DEPTH = 1 << `CRAM_ADDR_W; // 16 banks x 8 KB

	logic [`CART_DATA_W-1:0] mem [0:DEPTH-1];
	logic [`CART_DATA_W-1:0] ram_q;  // raw stored byte
	logic                    en_q;   // ram_enable at the read
	logic                    nib_q;  // mbc2 4-bit cell
	logic                    rtc_q;  // mbc3 pointing at the rtc

	// ------------------------------
	// storage, writes land even with the ram disabled
	always_ff @(posedge clk_sys) begin
		if (s2_cram_wr)
			mem[s2_cram_addr] <= s2_cram_data;
		if (s2_cram_rd) begin
			ram_q <= mem[s2_cram_addr];
			en_q  <= ram_enable;
			nib_q <= s2_mbc2_nibble;
			rtc_q <= rtc_mode && (mbc_kind == cart_pkg::MBC_3);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			cram_rd_valid <= 1'b0;
		else
			cram_rd_valid <= s2_cram_rd; // one cycle read
	end

	// ------------------------------
	// read data seen by the cpu
	always_comb begin
		if (!en_q)
			cram_rdata = `CRAM_OPEN_BUS;        // disabled ram floats high
		else if (nib_q)
			cram_rdata = {4'hF, ram_q[3:0]};    // only 4 bits exist on mbc2
		else if (rtc_q)
			cram_rdata = 8'h00;                 // no rtc behind it
		else
			cram_rdata = ram_q;
	end

	// a read leaving the address map returns exactly one cycle later
	a_rd_latency: assert property (@(posedge clk_sys) disable iff (reset)
		cram_rd_valid == $past(s2_cram_rd))
		else $error("cram_rd_valid %h, s2_cram_rd one cycle earlier %h",
			cram_rd_valid, $past(s2_cram_rd));

endmodule

//--- rtl/mbc_addr_map.sv
// pipeline stage 2: maps a cpu access to a rom word address or a cartridge ram address
`timescale 1ns/100ps
`include "cart_defs.svh"

module mbc_addr_map (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  cart_pkg::mbc_kind_t     mbc_kind,
	input  cart_pkg::rom_bank_t     rom_mask,
	input  cart_pkg::ram_bank_t     ram_mask,
	input  cart_pkg::rom_bank_t     rom_bank_reg,
	input  cart_pkg::ram_bank_t     ram_bank_reg,
	input  logic                    mbc1_mode,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [`DL_DATA_W-1:0]   dl_data,
	input  logic                    s1_rd,
	input  logic                    s1_wr,
	input  logic [`CART_ADDR_W-1:0] s1_addr,
	input  logic [`CART_DATA_W-1:0] s1_data,
	output logic                    rom_rd,
	output logic                    rom_wr,
	output logic [`ROM_WADDR_W-1:0] rom_addr,
	output logic [`DL_DATA_W-1:0]   rom_wdata,
	output logic                    s2_cram_rd,
	output logic                    s2_cram_wr,
	output logic [`CRAM_ADDR_W-1:0] s2_cram_addr,
	output logic [`CART_DATA_W-1:0] s2_cram_data,
	output logic                    s2_mbc2_nibble // a000-a1ff on mbc2, upper nibble open
);

	logic                    dl_wr_q;    // download word aligned with stage 1
	logic [`ROM_WADDR_W-1:0] dl_waddr_q;
	logic [`DL_DATA_W-1:0]   dl_data_q;
	cart_pkg::rom_bank_t     upper_bank; // bank seen at 4000-7fff
	cart_pkg::rom_bank_t     rom_bank;
	cart_pkg::ram_bank_t     cram_bank;
	logic                    rom_win;
	logic                    cram_win;

	assign rom_win  = !s1_addr[15];
	assign cram_win = (s1_addr[15:13] == `WIN_CRAM);

	// ------------------------------
	// rom bank per mapper, masked for mirroring of small roms
	always_comb begin
		case (mbc_kind)
			cart_pkg::MBC_1: upper_bank = {2'b00, mbc1_mode ? 2'b00 : ram_bank_reg[1:0],
				rom_bank_reg[4:0]} & rom_mask;
			cart_pkg::MBC_2,
			cart_pkg::MBC_3: upper_bank = {2'b00, rom_bank_reg[6:0]} & rom_mask;
			cart_pkg::MBC_5: upper_bank = rom_bank_reg & rom_mask; // full 9 bits
			default:         upper_bank = 9'd1; // no mbc, 32k linear
		endcase
		rom_bank = s1_addr[14] ? upper_bank : 9'd0; // 0000-3fff is always bank 0
	end

	// ram bank: mbc1 only banks in mode 1, mbc2 has one internal bank
	always_comb begin
		case (mbc_kind)
			cart_pkg::MBC_1: cram_bank = (mbc1_mode ? ram_bank_reg : 4'h0) & ram_mask;
			cart_pkg::MBC_3,
			cart_pkg::MBC_5: cram_bank = ram_bank_reg & ram_mask;
			default:         cram_bank = 4'h0;
		endcase
	end

	// ------------------------------
	// strobes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_wr_q    <= 1'b0;
			rom_rd     <= 1'b0;
			rom_wr     <= 1'b0;
			s2_cram_rd <= 1'b0;
			s2_cram_wr <= 1'b0;
		end else begin
			dl_wr_q    <= dl_wr;
			rom_wr     <= dl_wr_q;
			rom_rd     <= s1_rd && rom_win && !dl_wr_q; // download owns the rom port
			s2_cram_rd <= s1_rd && cram_win;
			s2_cram_wr <= s1_wr && cram_win;
		end
	end

	// payload
	always_ff @(posedge clk_sys) begin
		dl_waddr_q     <= dl_addr[`ROM_WADDR_W:1]; // byte to word address
		dl_data_q      <= dl_data;
		rom_addr       <= dl_wr_q ? dl_waddr_q : {rom_bank, s1_addr[13:1]};
		rom_wdata      <= dl_data_q;
		s2_cram_addr   <= {cram_bank, s1_addr[12:0]};
		s2_cram_data   <= s1_data;
		s2_mbc2_nibble <= (mbc_kind == cart_pkg::MBC_2) && (s1_addr[15:9] == `MBC2_NIB_WIN);
	end

endmodule

//--- rtl/mbc_bank_regs.sv
// pipeline stage 1: bank select registers written by the cpu, each access forwarded one cycle later
`timescale 1ns/100ps
`include "cart_defs.svh"

module mbc_bank_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,   // holds the registers at their reset values
	input  cart_pkg::mbc_kind_t     mbc_kind,
	input  logic                    cart_rd,
	input  logic                    cart_wr,
	input  logic [`CART_ADDR_W-1:0] cart_addr,
	input  logic [`CART_DATA_W-1:0] cart_di,
	output cart_pkg::rom_bank_t     rom_bank_reg,
	output cart_pkg::ram_bank_t     ram_bank_reg,
	output logic                    mbc1_mode,   // 1 = 4/32 mode, ram banked
	output logic                    rtc_mode,    // mbc3 a000-bfff points at the rtc
	output logic                    ram_enable,
	output logic                    s1_rd,
	output logic                    s1_wr,
	output logic [`CART_ADDR_W-1:0] s1_addr,
	output logic [`CART_DATA_W-1:0] s1_data
);

	logic [2:0] win; // 8 KB window of the access
	logic       is_mbc5;

	assign win     = cart_addr[15:13];
	assign is_mbc5 = (mbc_kind == cart_pkg::MBC_5);

	// ------------------------------
	// register writes
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank_reg <= 9'd1;
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			ram_enable   <= 1'b0;
		end else if (cart_wr) begin
			case (win)
				`WIN_RAM_EN: ram_enable <= (cart_di[3:0] == `RAM_ENABLE_KEY);
				`WIN_ROM_BANK: begin
					if (is_mbc5) begin
						if (cart_addr[12])
							rom_bank_reg[8] <= cart_di[0];   // 3000-3fff high bit
						else
							rom_bank_reg[7:0] <= cart_di;    // 2000-2fff low byte
					end else if (cart_di[6:0] == 7'd0) begin
						rom_bank_reg <= 9'd1;                // bank 0 maps to 1 on mbc1-3
					end else begin
						rom_bank_reg <= {2'b00, cart_di[6:0]};
					end
				end
				`WIN_RAM_BANK: begin
					if (mbc_kind == cart_pkg::MBC_3) begin
						if (cart_di[3]) begin
							rtc_mode <= 1'b1; // 08-0c select an rtc register
						end else begin
							rtc_mode     <= 1'b0;
							ram_bank_reg <= {2'b00, cart_di[1:0]};
						end
					end else if (is_mbc5) begin
						ram_bank_reg <= cart_di[3:0];
					end else begin
						ram_bank_reg <= {2'b00, cart_di[1:0]}; // mbc1 upper bits
					end
				end
				`WIN_MODE: if (mbc_kind == cart_pkg::MBC_1) mbc1_mode <= cart_di[0];
				default: ; // a000-ffff is not a register
			endcase
		end
	end

	// ------------------------------
	// forward the access to the address map
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			s1_rd <= 1'b0;
			s1_wr <= 1'b0;
		end else begin
			s1_rd <= cart_rd;
			s1_wr <= cart_wr;
		end
	end

	always_ff @(posedge clk_sys) begin
		s1_addr <= cart_addr;
		s1_data <= cart_di;
	end

	a_rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(cart_rd && cart_wr))
		else $error("cart_rd and cart_wr strobed together");

	// bank 0 remap must hold across header loads and register writes
	a_no_bank0: assert property (@(posedge clk_sys) disable iff (reset || dl_active)
		(mbc_kind inside {cart_pkg::MBC_1, cart_pkg::MBC_2, cart_pkg::MBC_3})
		|-> (rom_bank_reg != 9'd0))
		else $error("rom bank 0 on mbc1-3, bank %h", rom_bank_reg);

endmodule

//--- rtl/cart_header_capture.sv
// snoops the rom download for the cartridge header and decodes mapper kind and bank masks
`timescale 1ns/100ps
`include "cart_defs.svh"

module cart_header_capture (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active, // high for the whole image load
	input  logic                   dl_wr,     // one word per strobe
	input  logic [`DL_ADDR_W-1:0]  dl_addr,
	input  logic [`DL_DATA_W-1:0]  dl_data,
	output cart_pkg::mbc_kind_t    mbc_kind,
	output cart_pkg::rom_bank_t    rom_mask,
	output cart_pkg::ram_bank_t    ram_mask
);

	logic [7:0] cart_type; // header 0x147
	logic [7:0] rom_size;  // header 0x148
	logic [7:0] ram_size;  // header 0x149

	// header bytes, valid from the edge that samples their word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_type <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == `HDR_TYPE_OFS)
				cart_type <= dl_data[15:8]; // low byte is the sgb flag, not kept
			if (dl_addr == `HDR_SIZE_OFS) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// ------------------------------
	// decode

	always_comb begin
		case (cart_type) inside
			[8'd1:8'd3]:   mbc_kind = cart_pkg::MBC_1;
			[8'd5:8'd6]:   mbc_kind = cart_pkg::MBC_2;
			[8'd15:8'd19]: mbc_kind = cart_pkg::MBC_3;
			[8'd25:8'd30]: mbc_kind = cart_pkg::MBC_5;
			default:       mbc_kind = cart_pkg::MBC_NONE; // mmm01, huc, tama etc not mapped
		endcase
	end

	// code n keeps the low n+1 bank bits, so 0 -> 2 banks and 8 -> 512 banks
	always_comb begin
		if (rom_size <= 8'd8)
			rom_mask = ~(9'h1FF << (rom_size[3:0] + 4'd1));
		else
			rom_mask = 9'h07F; // odd sizes 0x52..0x54 treated as 128 banks
	end

	always_comb begin
		if (ram_size >= 8'd4)
			ram_mask = 4'hF; // 128k, 16 banks
		else if (ram_size == 8'd3)
			ram_mask = 4'h3; // 32k, 4 banks
		else
			ram_mask = 4'h0; // none, 2k or 8k: single bank
	end

	// the header can only arrive as part of an image load
	a_dl_in_window: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> dl_active)
		else $error("dl_wr outside dl_active");

endmodule

//--- rtl/cart_pkg.sv
// shared types of the cartridge mapper, referenced as cart_pkg::name by every stage
`include "cart_defs.svh"

package cart_pkg;

	// ------------------------------
	// mapper kind, decoded once from the header type byte
	typedef enum logic [2:0] {
		MBC_NONE = 3'd0, // plain 32k rom, bank from address bit 14
		MBC_1    = 3'd1, // types 1..3
		MBC_2    = 3'd2, // types 5..6, built-in 512 x 4 ram
		MBC_3    = 3'd3, // types 15..19, rtc mode reads zero here
		MBC_5    = 3'd5  // types 25..30, nine bit rom bank
	} mbc_kind_t;

	// ------------------------------
	// bank numbers

	// rom bank, also used for the rom size mask
	typedef logic [`ROM_BANK_W-1:0] rom_bank_t;

	// ram bank, also used for the ram size mask
	typedef logic [`RAM_BANK_W-1:0] ram_bank_t;

endpackage

//--- rtl/cart_defs.svh
// widths, cpu address windows and header constants of the cartridge mapper, include where needed
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// ------------------------------
// bus widths
`define CART_ADDR_W 16 // cpu cartridge address
`define CART_DATA_W 8  // cpu data byte
`define DL_ADDR_W   25 // download byte address
`define DL_DATA_W   16 // download word, low byte at the even address
`define ROM_WADDR_W 22 // 9 bank bits + 13 word-offset bits
`define CRAM_ADDR_W 17 // 128 KB of cartridge ram
`define ROM_BANK_W  9  // up to 512 banks for mbc5
`define RAM_BANK_W  4  // up to 16 banks of 8 KB

// ------------------------------
// cpu windows, compared against cart_addr[15:13]
`define WIN_RAM_EN   3'b000     // 0000-1fff ram enable
`define WIN_ROM_BANK 3'b001     // 2000-3fff rom bank select
`define WIN_RAM_BANK 3'b010     // 4000-5fff ram bank / rtc select
`define WIN_MODE     3'b011     // 6000-7fff mbc1 mode
`define WIN_CRAM     3'b101     // a000-bfff cartridge ram
`define MBC2_NIB_WIN 7'b1010000 // cart_addr[15:9], the 512 x 4 mbc2 ram

// ------------------------------
// header and magic values
`define HDR_TYPE_OFS   'h146 // high byte = cartridge type
`define HDR_SIZE_OFS   'h148 // low byte = rom size, high byte = ram size
`define RAM_ENABLE_KEY 4'hA  // low nibble that opens the ram
`define CRAM_OPEN_BUS  8'hFF // what a disabled ram reads back as

`endif
